// File: compile.f
+incdir+include
src/vshift_pkg.sv
src/vshift_operand_stage.sv
src/vshift_lanes.sv
src/vshift_result_stage.sv
src/vshift_unit.sv
dv/vshift_checker.sv
dv/vshift_tb.sv

// File: dv/vshift_tb.sv
`timescale 1ns/10ps
`include "shift_macros.svh"

module vshift_tb;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      in_req;
  logic                      in_ack;
  vshift_pkg::shift_uop_t    uop;
  logic                      out_req;
  logic                      out_ack;
  vshift_pkg::shift_result_t result;

  vshift_pkg::shift_uop_t stim_q[$];
  vshift_pkg::shift_uop_t pend_q[$];
  int   data_errs = 0;
  int   vxsat_errs = 0;
  int   other_errs = 0;
  int   n_checked = 0;
  int   cycles = 0;
  int   limit = 0;
  int   bp_start = 0;
  logic bp_en = 1'b0;
  logic ack_prev = 1'b0;

  vshift_unit DUT (
    .clk     (clk),
    .rst     (rst),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .uop     (uop),
    .out_req (out_req),
    .out_ack (out_ack),
    .result  (result)
  );

  bind vshift_unit vshift_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .result  (result)
  );

  always #4 clk = ~clk;

  function automatic vshift_pkg::shift_uop_t make_uop(input int op, input int form,
                                                      input int eew, input int vxrm,
                                                      input int half);
    vshift_pkg::shift_uop_t u;
    u.op   = vshift_pkg::shift_op_e'(op);
    u.form = vshift_pkg::opnd_form_e'(form);
    u.eew  = vshift_pkg::eew_e'(eew);
    u.vxrm = vshift_pkg::vxrm_e'(vxrm);
    u.half = half[0];
    u.vs2  = {$urandom(), $urandom(), $urandom(), $urandom()};
    u.vs1  = {$urandom(), $urandom(), $urandom(), $urandom()};
    u.rs1  = $urandom();
    return u;
  endfunction

  // expected result straight from the element rules
  function automatic vshift_pkg::shift_result_t vshift_ref(input vshift_pkg::shift_uop_t u);
    vshift_pkg::shift_result_t res;
    vshift_pkg::vreg_t         slice;
    int                        e;
    int                        s;
    longint                    emask;
    longint                    hmask;
    longint                    x;
    longint                    sh;
    longint                    v;
    longint                    hi;
    longint                    lo;
    longint                    elem;
    logic                      r;
    logic                      arith;
    logic                      narrow;
    res    = '0;
    e      = `BYTE_WIDTH << u.eew;
    emask  = (longint'(1) << e) - 1;
    hmask  = (longint'(1) << (e / 2)) - 1;
    arith  = u.op inside {vshift_pkg::VSRA, vshift_pkg::VSSRA, vshift_pkg::VNSRA,
                          vshift_pkg::VNCLIP};
    narrow = u.op inside {vshift_pkg::VNSRL, vshift_pkg::VNSRA, vshift_pkg::VNCLIPU,
                          vshift_pkg::VNCLIP};
    if (narrow && u.eew == vshift_pkg::EEW8) return res;
    for (int i = 0; i < `VLEN / e; i++) begin
      slice = u.vs2 >> (i * e);
      x     = longint'(slice[31:0]) & emask;
      if (arith && x[e-1]) x = x - (longint'(1) << e);
      slice = u.vs1 >> (i * e);
      s     = (u.form == vshift_pkg::VV) ? int'(slice[4:0]) : int'(u.rs1[4:0]);
      s     = s & (e - 1);
      if (u.op == vshift_pkg::VSLL) sh = (x << s) & emask;
      else sh = x >>> s;
      r = 1'b0;
      if (s > 0) begin
        case (u.vxrm)
          vshift_pkg::RNU: r = x[s-1];
          vshift_pkg::RNE: r = x[s-1] & (((x & ((longint'(1) << (s - 1)) - 1)) != 0) | sh[0]);
          vshift_pkg::ROD: r = !sh[0] && ((x & ((longint'(1) << s) - 1)) != 0);
          default:         r = 1'b0;
        endcase
      end
      v = sh + r;
      case (u.op)
        vshift_pkg::VSSRL, vshift_pkg::VSSRA: elem = v & emask;
        vshift_pkg::VNSRL, vshift_pkg::VNSRA: elem = sh & hmask;
        vshift_pkg::VNCLIPU, vshift_pkg::VNCLIP: begin
          hi = (u.op == vshift_pkg::VNCLIPU) ? hmask : (hmask >> 1);
          lo = (u.op == vshift_pkg::VNCLIPU) ? 0 : -(hmask >> 1) - 1;
          if (v > hi || v < lo) res.vxsat = 1'b1;
          elem = ((v > hi) ? hi : (v < lo) ? lo : v) & hmask;
        end
        default: elem = sh & emask;
      endcase
      if (narrow) res.data |= vshift_pkg::vreg_t'(elem) << (i * e / 2 + (u.half ? `VLEN / 2 : 0));
      else res.data |= vshift_pkg::vreg_t'(elem) << (i * e);
    end
    return res;
  endfunction

  task automatic send_uop(input vshift_pkg::shift_uop_t u);
    @(posedge clk);
    in_req <= 1'b1;
    uop    <= u;
    do @(negedge clk); while (!in_ack);
    @(posedge clk);
    in_req <= 1'b0;
    do @(negedge clk); while (in_ack);
  endtask

  task automatic check_result();
    vshift_pkg::shift_result_t exp;
    if (pend_q.size() == 0) begin
      other_errs++;
      $display("out_req rose at %0t ns with no accepted uop waiting for a result", $time);
      return;
    end
    exp = vshift_ref(pend_q.pop_front());
    n_checked++;
    assert (result.data === exp.data) else begin
      data_errs++;
      $display("ERROR at %0t ns: result.data expected %h, got %h", $time, exp.data, result.data);
    end
    assert (result.vxsat === exp.vxsat) else begin
      vxsat_errs++;
      $display("ERROR at %0t ns: result.vxsat expected %b, got %b", $time, exp.vxsat,
               result.vxsat);
    end
  endtask

  task automatic report_counts();
    $display("checked %0d of %0d: %0d data, %0d vxsat, %0d other, %0d assertion errors",
             n_checked, stim_q.size(), data_errs, vxsat_errs, other_errs,
             DUT.u_checker.fail_count);
  endtask

  // uop is still held when in_ack rises
  always @(negedge clk) begin
    if (in_ack && !ack_prev) pend_q.push_back(uop);
    ack_prev = in_ack;
  end

  initial begin : respond
    int delay;
    out_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (out_req) begin
        check_result();
        delay = bp_en ? $urandom_range(10, 0) : 0;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        out_ack <= 1'b1;
        do @(negedge clk); while (out_req);
        @(posedge clk);
        out_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("run timed out after %0d cycles before all results came back", cycles);
      report_counts();
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin : stimulus
    int op;
    void'($urandom(32'h95cb_36ff));
    rst    = 1'b1;
    in_req = 1'b0;
    uop    = '0;
    for (int o = 0; o < 3; o++)
      for (int w = 0; w < 3; w++)
        for (int f = 0; f < 2; f++)
          stim_q.push_back(make_uop(o, f, w, $urandom_range(3, 0), 0));
    for (int o = 3; o < 5; o++)
      for (int m = 0; m < 4; m++)
        for (int w = 0; w < 3; w++)
          stim_q.push_back(make_uop(o, $urandom_range(1, 0), w, m, 0));
    for (int o = 5; o < 9; o++)
      for (int w = 1; w < 3; w++)
        for (int h = 0; h < 2; h++)
          for (int m = 0; m < ((o < 7) ? 1 : 4); m++)
            stim_q.push_back(make_uop(o, $urandom_range(1, 0), w, m, h));
    // narrowing from bytes is illegal
    for (int o = 5; o < 9; o++)
      stim_q.push_back(make_uop(o, $urandom_range(1, 0), 0, $urandom_range(3, 0),
                                $urandom_range(1, 0)));
    bp_start = stim_q.size();
    repeat (20) begin
      op = $urandom_range(8, 0);
      stim_q.push_back(make_uop(op, $urandom_range(1, 0),
                                (op >= 5) ? $urandom_range(2, 1) : $urandom_range(2, 0),
                                $urandom_range(3, 0), $urandom_range(1, 0)));
    end
    limit = 60 * stim_q.size() + 200;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    foreach (stim_q[k]) begin
      if (k == bp_start) bp_en = 1'b1;
      send_uop(stim_q[k]);
    end
    while (n_checked < stim_q.size()) @(negedge clk);
    report_counts();
    if (data_errs + vxsat_errs + other_errs + DUT.u_checker.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: dv/vshift_checker.sv
`timescale 1ns/10ps

module vshift_checker (
  input logic                      clk,
  input logic                      rst,
  input logic                      in_req,
  input logic                      in_ack,
  input logic                      out_req,
  input logic                      out_ack,
  input vshift_pkg::shift_result_t result
);

  int fail_count = 0;

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(in_ack) |-> in_req)
    else begin
      fail_count++;
      $error("in_ack rose while in_req was low");
    end

  req_held: assert property (@(posedge clk) disable iff (rst)
    out_req && !out_ack |=> out_req)
    else begin
      fail_count++;
      $error("out_req dropped before out_ack arrived");
    end

  result_stable: assert property (@(posedge clk) disable iff (rst)
    out_req |=> !out_req || $stable(result))
    else begin
      fail_count++;
      $error("result changed while out_req was high");
    end

  // first cycle out of reset has no request
  req_low_after_rst: assert property (@(posedge clk)
    rst |=> !out_req)
    else begin
      fail_count++;
      $error("out_req high in the cycle after reset");
    end

endmodule

// File: src/vshift_unit.sv
`timescale 1ns/10ps

module vshift_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_req,
  output logic                      in_ack,
  input  vshift_pkg::shift_uop_t    uop,
  output logic                      out_req,
  input  logic                      out_ack,
  output vshift_pkg::shift_result_t result
);

  vshift_pkg::shift_work_t work;
  vshift_pkg::lane_out_t   lanes;
  logic                    work_valid;
  logic                    work_take;

  vshift_operand_stage u_operand (
    .clk        (clk),
    .rst        (rst),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .uop        (uop),
    .work_take  (work_take),
    .work       (work),
    .work_valid (work_valid)
  );

  vshift_lanes u_lanes (
    .work  (work),
    .lanes (lanes)
  );

  vshift_result_stage u_result (
    .clk        (clk),
    .rst        (rst),
    .work       (work),
    .work_valid (work_valid),
    .lanes      (lanes),
    .work_take  (work_take),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .result     (result)
  );

endmodule

// File: src/vshift_result_stage.sv
`timescale 1ns/10ps
`include "shift_macros.svh"

module vshift_result_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  vshift_pkg::shift_work_t   work,
  input  logic                      work_valid,
  input  vshift_pkg::lane_out_t     lanes,
  output logic                      work_take,
  output logic                      out_req,
  input  logic                      out_ack,
  output vshift_pkg::shift_result_t result
);

  localparam int HALF = `VLEN / 2;

  vshift_pkg::out_state_e    state;
  vshift_pkg::out_state_e    state_next;
  vshift_pkg::shift_result_t res_next;

  // clip to h bits, top bit of the return flags saturation
  function automatic logic [`HWORD_WIDTH:0] clip_elem(input logic signed [`WORD_WIDTH:0] v,
                                                      input logic is_signed,
                                                      input int h);
    int hi;
    int lo;
    hi = is_signed ? (1 <<< (h - 1)) - 1 : (1 <<< h) - 1;
    lo = is_signed ? -(1 <<< (h - 1)) : 0;
    if (v > hi) return {1'b1, hi[`HWORD_WIDTH-1:0]};
    if (v < lo) return {1'b1, lo[`HWORD_WIDTH-1:0]};
    return {1'b0, v[`HWORD_WIDTH-1:0]};
  endfunction

  always_comb begin : data_sel
    logic [HALF-1:0]             narrow;
    logic signed [`WORD_WIDTH:0] v;
    logic [`HWORD_WIDTH:0]       c;
    logic                        clip_op;
    logic                        sgn;
    clip_op  = (work.op == vshift_pkg::VNCLIPU) | (work.op == vshift_pkg::VNCLIP);
    sgn      = (work.kind == vshift_pkg::SRA);
    narrow   = '0;
    res_next = '0;
    case (work.eew)
      vshift_pkg::EEW16: begin
        for (int i = 0; i < `VLEN / `HWORD_WIDTH; i++) begin
          v = sgn ? {{`HWORD_WIDTH{lanes.carry[i]}}, lanes.carry[i],
                     lanes.rounded[i*`HWORD_WIDTH +: `HWORD_WIDTH]}
                  : {{`HWORD_WIDTH{1'b0}}, lanes.carry[i],
                     lanes.rounded[i*`HWORD_WIDTH +: `HWORD_WIDTH]};
          c = clip_elem(v, sgn, `BYTE_WIDTH);
          narrow[i*`BYTE_WIDTH +: `BYTE_WIDTH] =
            clip_op ? c[`BYTE_WIDTH-1:0] : lanes.shifted[i*`HWORD_WIDTH +: `BYTE_WIDTH];
          res_next.vxsat |= clip_op & c[`HWORD_WIDTH];
        end
      end
      vshift_pkg::EEW32: begin
        for (int i = 0; i < `VLEN / `WORD_WIDTH; i++) begin
          v = {lanes.carry[2*i], lanes.rounded[i*`WORD_WIDTH +: `WORD_WIDTH]};
          c = clip_elem(v, sgn, `HWORD_WIDTH);
          narrow[i*`HWORD_WIDTH +: `HWORD_WIDTH] =
            clip_op ? c[`HWORD_WIDTH-1:0] : lanes.shifted[i*`WORD_WIDTH +: `HWORD_WIDTH];
          res_next.vxsat |= clip_op & c[`HWORD_WIDTH];
        end
      end
      // no narrow form from bytes, result stays zero
      default: ;
    endcase
    case (work.op)
      vshift_pkg::VSLL,
      vshift_pkg::VSRL,
      vshift_pkg::VSRA: res_next.data = lanes.shifted;
      vshift_pkg::VSSRL,
      vshift_pkg::VSSRA: res_next.data = lanes.rounded;
      default: res_next.data = work.half ? {narrow, {HALF{1'b0}}} : {{HALF{1'b0}}, narrow};
    endcase
  end

  // take only into an empty result register
  assign work_take = (state == vshift_pkg::EMPTY) & work_valid;
  assign out_req   = (state == vshift_pkg::SEND);

  always_comb begin
    state_next = state;
    case (state)
      vshift_pkg::EMPTY: begin
        if (work_valid) state_next = vshift_pkg::SEND;
      end
      vshift_pkg::SEND: begin
        if (out_ack) state_next = vshift_pkg::WAIT_ACK_LOW;
      end
      vshift_pkg::WAIT_ACK_LOW: begin
        if (!out_ack) state_next = vshift_pkg::EMPTY;
      end
      default: state_next = vshift_pkg::EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= vshift_pkg::EMPTY;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (work_take) result <= res_next;
  end

endmodule

// File: src/vshift_lanes.sv
`timescale 1ns/10ps
`include "shift_macros.svh"

module vshift_lanes (
  input  vshift_pkg::shift_work_t work,
  output vshift_pkg::lane_out_t   lanes
);

  // one block per element width 8, 16, 32
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int E = `BYTE_WIDTH << w;
    localparam int N = `VLEN / E;
    localparam int A = $clog2(E);

    wire vshift_pkg::vreg_t shf;
    wire vshift_pkg::vreg_t rnd;
    wire [N-1:0]            cout;

    for (genvar i = 0; i < N; i++) begin : g_elem
      logic [E-1:0]        x;
      logic [A-1:0]        s;
      logic signed [2*E:0] wide;
      logic [E-1:0]        sh;
      logic [E-1:0]        lost;
      logic                r;
      logic [E:0]          sum;

      assign x = work.src[i*E +: E];
      assign s = work.amt[i*E +: A];

      // bits shifted out end up in the low half
      assign wide = $signed({(work.kind == vshift_pkg::SRA) & x[E-1], x, {E{1'b0}}}) >>> s;
      assign sh   = (work.kind == vshift_pkg::SLL) ? x << s : wide[2*E-1:E];
      assign lost = wide[E-1:0];

      // lost is zero for s == 0 so r is zero too
      always_comb begin
        case (work.vxrm)
          vshift_pkg::RNU: r = lost[E-1];
          vshift_pkg::RNE: r = lost[E-1] & ((|lost[E-2:0]) | sh[0]);
          vshift_pkg::RDN: r = 1'b0;
          vshift_pkg::ROD: r = ~sh[0] & (|lost);
          default:         r = 1'b0;
        endcase
      end

      // extended by one bit so the clip check sees the true sign
      assign sum = {(work.kind == vshift_pkg::SRA) & sh[E-1], sh} + {{E{1'b0}}, r};

      assign shf[i*E +: E] = sh;
      assign rnd[i*E +: E] = sum[E-1:0];
      assign cout[i]       = sum[E];
    end
  end

  always_comb begin
    lanes = '0;
    case (work.eew)
      vshift_pkg::EEW8: begin
        lanes.shifted = g_width[0].shf;
        lanes.rounded = g_width[0].rnd;
      end
      vshift_pkg::EEW16: begin
        lanes.shifted = g_width[1].shf;
        lanes.rounded = g_width[1].rnd;
        lanes.carry   = g_width[1].cout;
      end
      vshift_pkg::EEW32: begin
        lanes.shifted = g_width[2].shf;
        lanes.rounded = g_width[2].rnd;
        // word carry sits in the lower slot of the pair
        for (int i = 0; i < `VLEN / `WORD_WIDTH; i++) begin
          lanes.carry[2*i] = g_width[2].cout[i];
        end
      end
      default: ;
    endcase
  end

endmodule

// File: src/vshift_operand_stage.sv
`timescale 1ns/10ps
`include "shift_macros.svh"

module vshift_operand_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_req,
  output logic                    in_ack,
  input  vshift_pkg::shift_uop_t  uop,
  input  logic                    work_take,
  output vshift_pkg::shift_work_t work,
  output logic                    work_valid
);

  vshift_pkg::oper_state_e state;
  vshift_pkg::oper_state_e state_next;
  vshift_pkg::shift_kind_e kind_next;
  vshift_pkg::vreg_t       bcast;
  vshift_pkg::vreg_t       mask;
  vshift_pkg::vreg_t       amt_next;
  logic                    capture;

  // new uop only when the register is free
  assign capture = (state == vshift_pkg::IDLE) & in_req & ~work_valid;
  assign in_ack  = (state != vshift_pkg::IDLE);

  always_comb begin
    state_next = state;
    case (state)
      vshift_pkg::IDLE: begin
        if (capture) state_next = vshift_pkg::HOLD;
      end
      vshift_pkg::HOLD: begin
        if (!in_req) state_next = vshift_pkg::IDLE;
        else if (work_take) state_next = vshift_pkg::WAIT_REQ_LOW;
      end
      vshift_pkg::WAIT_REQ_LOW: begin
        if (!in_req) state_next = vshift_pkg::IDLE;
      end
      default: state_next = vshift_pkg::IDLE;
    endcase
  end

  always_comb begin
    case (uop.op)
      vshift_pkg::VSLL: kind_next = vshift_pkg::SLL;
      vshift_pkg::VSRL,
      vshift_pkg::VSSRL,
      vshift_pkg::VNSRL,
      vshift_pkg::VNCLIPU: kind_next = vshift_pkg::SRL;
      default: kind_next = vshift_pkg::SRA;
    endcase
  end

  // scalar amount replicated per element, then cut to log2(eew) bits
  always_comb begin
    bcast = '0;
    mask  = '0;
    case (uop.eew)
      vshift_pkg::EEW8: begin
        bcast = {(`VLEN/`BYTE_WIDTH){uop.rs1[`BYTE_WIDTH-1:0]}};
        mask  = {(`VLEN/`BYTE_WIDTH){`BYTE_WIDTH'(`BYTE_WIDTH-1)}};
      end
      vshift_pkg::EEW16: begin
        bcast = {(`VLEN/`HWORD_WIDTH){uop.rs1[`HWORD_WIDTH-1:0]}};
        mask  = {(`VLEN/`HWORD_WIDTH){`HWORD_WIDTH'(`HWORD_WIDTH-1)}};
      end
      vshift_pkg::EEW32: begin
        bcast = {(`VLEN/`WORD_WIDTH){uop.rs1[`WORD_WIDTH-1:0]}};
        mask  = {(`VLEN/`WORD_WIDTH){`WORD_WIDTH'(`WORD_WIDTH-1)}};
      end
      default: ;
    endcase
    amt_next = ((uop.form == vshift_pkg::VV) ? uop.vs1 : bcast) & mask;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= vshift_pkg::IDLE;
      work_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (capture) work_valid <= 1'b1;
      else if (work_take) work_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      work.op   <= uop.op;
      work.kind <= kind_next;
      work.eew  <= uop.eew;
      work.vxrm <= uop.vxrm;
      work.half <= uop.half;
      work.src  <= uop.vs2;
      work.amt  <= amt_next;
    end
  end

endmodule

// File: src/vshift_pkg.sv
`include "shift_macros.svh"

package vshift_pkg;

  typedef logic [`VLEN-1:0] vreg_t;
  typedef logic [`XLEN-1:0] xreg_t;

  typedef enum logic [3:0] {
    VSLL,
    VSRL,
    VSRA,
    VSSRL,
    VSSRA,
    VNSRL,
    VNSRA,
    VNCLIPU,
    VNCLIP
  } shift_op_e;

  typedef enum logic [1:0] {SLL, SRL, SRA} shift_kind_e;
  typedef enum logic [1:0] {EEW8, EEW16, EEW32} eew_e;
  typedef enum logic [1:0] {RNU, RNE, RDN, ROD} vxrm_e;
  typedef enum logic {VV, SCALAR} opnd_form_e;

  typedef enum logic [1:0] {IDLE, HOLD, WAIT_REQ_LOW} oper_state_e;
  typedef enum logic [1:0] {EMPTY, SEND, WAIT_ACK_LOW} out_state_e;

  // uop as delivered by the issue side
  typedef struct packed {
    shift_op_e  op;
    opnd_form_e form;
    eew_e       eew;
    vxrm_e      vxrm;
    logic       half;
    vreg_t      vs2;
    vreg_t      vs1;
    xreg_t      rs1;
  } shift_uop_t;

  // amt keeps each element's amount in the low bits of its slot
  typedef struct packed {
    shift_op_e   op;
    shift_kind_e kind;
    eew_e        eew;
    vxrm_e       vxrm;
    logic        half;
    vreg_t       src;
    vreg_t       amt;
  } shift_work_t;

  // carry has one bit per 16-bit slot
  typedef struct packed {
    vreg_t                        shifted;
    vreg_t                        rounded;
    logic [`VLEN/`HWORD_WIDTH-1:0] carry;
  } lane_out_t;

  typedef struct packed {
    vreg_t data;
    logic  vxsat;
  } shift_result_t;

endpackage

// File: include/shift_macros.svh
`ifndef SHIFT_MACROS_SVH
`define SHIFT_MACROS_SVH

// vector register width
`define VLEN 128

// scalar register width
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

`endif
